// ==== cpuPkg.sv ====
package cpuPkg;

    // Data and address word
    typedef logic [31:0] wordT;

    // Instruction field widths
    typedef logic [4:0] regIndexT;
    typedef logic [4:0] shamtT;
    typedef logic [15:0] immT;
    typedef logic [25:0] targetT;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'd0,
        opRegimm  = 6'd1,
        opJ       = 6'd2,
        opJal     = 6'd3,
        opBeq     = 6'd4,
        opBne     = 6'd5,
        opBlez    = 6'd6,
        opBgtz    = 6'd7,
        opAddiu   = 6'd9,
        opSlti    = 6'd10,
        opSltiu   = 6'd11,
        opAndi    = 6'd12,
        opOri     = 6'd13,
        opXori    = 6'd14,
        opLui     = 6'd15,
        opLw      = 6'd35,
        opSw      = 6'd43
    } opcodeT;

    // Function codes under SPECIAL
    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnSllv = 6'd4,
        fnSrlv = 6'd6,
        fnSrav = 6'd7,
        fnJr   = 6'd8,
        fnJalr = 6'd9,
        fnAddu = 6'd33,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSltu = 6'd43
    } functT;

    // Condition picked by rt under REGIMM
    typedef enum logic [4:0] {
        rtBltz = 5'd0,
        rtBgez = 5'd1
    } regimmT;

    // R-type layout
    // Immediate is bits 15:0, jump target bits 25:0 of the same word
    typedef struct packed {
        opcodeT   opcode;
        regIndexT rs;
        regIndexT rt;
        regIndexT rd;
        shamtT    shamt;
        functT    funct;
    } instrT;

    typedef enum logic [3:0] {
        aluNone,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui
    } aluOpT;

    // Boot ROM entry point
    localparam wordT resetVector = 32'hBFC0_0000;
    // Fetching from here ends the run
    localparam wordT haltAddress = 32'h0000_0000;
    localparam regIndexT returnRegister = 5'd31;
    // $v0
    localparam regIndexT resultRegister = 5'd2;
    localparam wordT wordBytes = 32'd4;

endpackage

// ==== busPkg.sv ====
package busPkg;

    // One enable per byte lane of a word
    localparam int byteEnableWidth = 4;

    typedef logic [byteEnableWidth-1:0] byteEnableT;

    // Word-only accesses, every lane on
    localparam byteEnableT allBytes = '1;

    // Avalon-MM master request, held steady under waitrequest
    typedef struct packed {
        cpuPkg::wordT address;
        logic         read;
        logic         write;
        cpuPkg::wordT writeData;
        byteEnableT   byteEnable;
    } busRequestT;

endpackage

// ==== registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::regIndexT readIndexA,
    input  cpuPkg::regIndexT readIndexB,
    input  cpuPkg::regIndexT writeIndex,
    input  logic             writeEnable,
    input  cpuPkg::wordT     writeData,
    output cpuPkg::wordT     readDataA,
    output cpuPkg::wordT     readDataB,
    output cpuPkg::wordT     registerV0
);

    cpuPkg::wordT registers [32];

    // Register zero is cleared by reset and never written after
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && (writeIndex != '0)) begin
            registers[writeIndex] <= writeData;
        end
    end

    // Asynchronous read ports
    assign readDataA = registers[readIndexA];
    assign readDataB = registers[readIndexB];

    // Debug tap on $v0
    assign registerV0 = registers[cpuPkg::resultRegister];

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpuPkg::instrT    instruction,
    input  cpuPkg::wordT     operandA,
    input  cpuPkg::wordT     operandB,
    output cpuPkg::wordT     result,
    output cpuPkg::regIndexT destination,
    output logic             writesRegister
);

    cpuPkg::aluOpT aluOp;
    cpuPkg::immT   immediate;
    cpuPkg::shamtT shiftAmount;
    cpuPkg::wordT  immExtended;
    cpuPkg::wordT  secondOperand;
    logic          useImmediate;
    logic          signExtend;

    // Immediate overlays rd, shamt and funct
    assign immediate = instruction[15:0];

    // Decode into operation, operand source and destination
    always_comb begin
        aluOp = cpuPkg::aluNone;
        useImmediate = 1'b1;
        signExtend = 1'b1;
        shiftAmount = instruction.shamt;
        destination = instruction.rt;
        writesRegister = 1'b0;
        case (instruction.opcode)
            cpuPkg::opSpecial: begin
                useImmediate = 1'b0;
                destination = instruction.rd;
                writesRegister = 1'b1;
                case (instruction.funct)
                    cpuPkg::fnAddu: aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor:  aluOp = cpuPkg::aluXor;
                    cpuPkg::fnSlt:  aluOp = cpuPkg::aluSlt;
                    cpuPkg::fnSltu: aluOp = cpuPkg::aluSltu;
                    cpuPkg::fnSll:  aluOp = cpuPkg::aluSll;
                    cpuPkg::fnSrl:  aluOp = cpuPkg::aluSrl;
                    cpuPkg::fnSra:  aluOp = cpuPkg::aluSra;
                    // Variable shifts take the amount from rs
                    cpuPkg::fnSllv: begin
                        aluOp = cpuPkg::aluSll;
                        shiftAmount = operandA[4:0];
                    end
                    cpuPkg::fnSrlv: begin
                        aluOp = cpuPkg::aluSrl;
                        shiftAmount = operandA[4:0];
                    end
                    cpuPkg::fnSrav: begin
                        aluOp = cpuPkg::aluSra;
                        shiftAmount = operandA[4:0];
                    end
                    // JR, JALR and anything unknown
                    default: writesRegister = 1'b0;
                endcase
            end
            cpuPkg::opAddiu: begin
                aluOp = cpuPkg::aluAdd;
                writesRegister = 1'b1;
            end
            cpuPkg::opSlti: begin
                aluOp = cpuPkg::aluSlt;
                writesRegister = 1'b1;
            end
            // Sign-extended, then compared unsigned
            cpuPkg::opSltiu: begin
                aluOp = cpuPkg::aluSltu;
                writesRegister = 1'b1;
            end
            cpuPkg::opAndi: begin
                aluOp = cpuPkg::aluAnd;
                signExtend = 1'b0;
                writesRegister = 1'b1;
            end
            cpuPkg::opOri: begin
                aluOp = cpuPkg::aluOr;
                signExtend = 1'b0;
                writesRegister = 1'b1;
            end
            cpuPkg::opXori: begin
                aluOp = cpuPkg::aluXor;
                signExtend = 1'b0;
                writesRegister = 1'b1;
            end
            cpuPkg::opLui: begin
                aluOp = cpuPkg::aluLui;
                writesRegister = 1'b1;
            end
            // Effective address, load data lands in writeback
            cpuPkg::opLw, cpuPkg::opSw: aluOp = cpuPkg::aluAdd;
            default: aluOp = cpuPkg::aluNone;
        endcase
    end

    assign immExtended = signExtend ? {{16{immediate[15]}}, immediate} : {16'h0000, immediate};
    assign secondOperand = useImmediate ? immExtended : operandB;

    // Shifts act on rt, which is the second operand for R-type
    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd:  result = operandA + secondOperand;
            cpuPkg::aluSub:  result = operandA - secondOperand;
            cpuPkg::aluAnd:  result = operandA & secondOperand;
            cpuPkg::aluOr:   result = operandA | secondOperand;
            cpuPkg::aluXor:  result = operandA ^ secondOperand;
            cpuPkg::aluSlt:  result = {31'd0, $signed(operandA) < $signed(secondOperand)};
            cpuPkg::aluSltu: result = {31'd0, operandA < secondOperand};
            cpuPkg::aluSll:  result = secondOperand << shiftAmount;
            cpuPkg::aluSrl:  result = secondOperand >> shiftAmount;
            cpuPkg::aluSra:  result = cpuPkg::wordT'($signed(secondOperand) >>> shiftAmount);
            cpuPkg::aluLui:  result = {immediate, 16'h0000};
            default:         result = '0;
        endcase
    end

endmodule

// ==== branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::instrT    instruction,
    input  cpuPkg::wordT     operandA,
    input  cpuPkg::wordT     operandB,
    input  cpuPkg::wordT     pc,
    input  logic             executeStrobe,
    output cpuPkg::wordT     nextPc,
    output logic             linkWrite,
    output cpuPkg::regIndexT linkIndex,
    output cpuPkg::wordT     linkValue
);

    cpuPkg::immT    offset;
    cpuPkg::targetT jumpField;
    cpuPkg::wordT   pcPlus4;
    cpuPkg::wordT   branchTarget;
    cpuPkg::wordT   jumpTarget;
    cpuPkg::wordT   target;
    cpuPkg::wordT   pendingTarget;
    logic           taken;
    logic           pendingValid;

    assign offset = instruction[15:0];
    assign jumpField = instruction[25:0];
    assign pcPlus4 = pc + cpuPkg::wordBytes;

    // Offsets are relative to the delay slot
    assign branchTarget = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};
    // J and JAL stay in the delay slot's 256 MB region
    assign jumpTarget = {pcPlus4[31:28], jumpField, 2'b00};

    always_comb begin
        taken = 1'b0;
        target = branchTarget;
        linkWrite = 1'b0;
        linkIndex = cpuPkg::returnRegister;
        case (instruction.opcode)
            cpuPkg::opSpecial: begin
                if (instruction.funct == cpuPkg::fnJr || instruction.funct == cpuPkg::fnJalr) begin
                    taken = 1'b1;
                    target = operandA;
                end
                if (instruction.funct == cpuPkg::fnJalr) begin
                    linkWrite = 1'b1;
                    linkIndex = instruction.rd;
                end
            end
            cpuPkg::opRegimm: begin
                case (cpuPkg::regimmT'(instruction.rt))
                    cpuPkg::rtBltz: taken = $signed(operandA) < 0;
                    cpuPkg::rtBgez: taken = $signed(operandA) >= 0;
                    default:        taken = 1'b0;
                endcase
            end
            cpuPkg::opJ: begin
                taken = 1'b1;
                target = jumpTarget;
            end
            cpuPkg::opJal: begin
                taken = 1'b1;
                target = jumpTarget;
                linkWrite = 1'b1;
            end
            cpuPkg::opBeq:  taken = operandA == operandB;
            cpuPkg::opBne:  taken = operandA != operandB;
            cpuPkg::opBlez: taken = $signed(operandA) <= 0;
            cpuPkg::opBgtz: taken = $signed(operandA) > 0;
            default:        taken = 1'b0;
        endcase
    end

    // Return address skips the delay slot
    assign linkValue = pcPlus4 + cpuPkg::wordBytes;

    // Pending target lives through exactly one more execute
    always_ff @(posedge clk) begin
        if (reset) begin
            pendingValid <= 1'b0;
        end else if (executeStrobe) begin
            pendingValid <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (executeStrobe && taken) begin
            pendingTarget <= target;
        end
    end

    // Delay slot itself sees the pending target here
    assign nextPc = pendingValid ? pendingTarget : pcPlus4;

endmodule

// ==== controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               waitRequest,
    input  cpuPkg::wordT       readData,
    output busPkg::busRequestT busRequest,
    output logic               active,
    output cpuPkg::instrT      instruction,
    output cpuPkg::wordT       pc,
    output logic               executeStrobe,
    input  cpuPkg::wordT       aluResult,
    input  cpuPkg::regIndexT   aluDestination,
    input  logic               aluWrites,
    input  cpuPkg::wordT       storeData,
    input  cpuPkg::wordT       nextPc,
    input  logic               linkWrite,
    input  cpuPkg::regIndexT   linkIndex,
    input  cpuPkg::wordT       linkValue,
    output logic               regWriteEnable,
    output cpuPkg::regIndexT   regWriteIndex,
    output cpuPkg::wordT       regWriteData
);

    typedef enum logic [2:0] {
        stateFetch,
        stateExecute,
        stateMemory,
        stateWriteback,
        stateHalt
    } stateT;

    stateT              state;
    stateT              stateNext;
    busPkg::busRequestT requestNext;
    cpuPkg::wordT       fetchAddress;
    cpuPkg::wordT       loadData;
    logic               fetchNeeded;
    logic               isLoad;
    logic               isStore;
    logic               accessDone;

    assign isLoad = instruction.opcode == cpuPkg::opLw;
    assign isStore = instruction.opcode == cpuPkg::opSw;

    // Avalon completion edge
    assign accessDone = (busRequest.read || busRequest.write) && !waitRequest;

    always_comb begin
        stateNext = state;
        requestNext = busRequest;
        fetchNeeded = 1'b0;
        fetchAddress = pc;
        case (state)
            stateFetch: begin
                // Nothing outstanding only right after reset
                if (!busRequest.read) begin
                    fetchNeeded = 1'b1;
                end else if (accessDone) begin
                    requestNext.read = 1'b0;
                    stateNext = stateExecute;
                end
            end
            stateExecute: begin
                if (isLoad || isStore) begin
                    // Address is the ALU add of rs and offset
                    requestNext.address = aluResult;
                    requestNext.read = isLoad;
                    requestNext.write = isStore;
                    requestNext.writeData = storeData;
                    requestNext.byteEnable = busPkg::allBytes;
                    stateNext = stateMemory;
                end else begin
                    fetchNeeded = 1'b1;
                    fetchAddress = nextPc;
                end
            end
            stateMemory: begin
                if (accessDone) begin
                    requestNext.read = 1'b0;
                    requestNext.write = 1'b0;
                    if (isLoad) begin
                        stateNext = stateWriteback;
                    end else begin
                        fetchNeeded = 1'b1;
                    end
                end
            end
            stateWriteback: fetchNeeded = 1'b1;
            default: stateNext = stateHalt;
        endcase
        // Next fetch, or halt when it would hit address zero
        if (fetchNeeded) begin
            if (fetchAddress == cpuPkg::haltAddress) begin
                stateNext = stateHalt;
            end else begin
                stateNext = stateFetch;
                requestNext.address = fetchAddress;
                requestNext.read = 1'b1;
                requestNext.write = 1'b0;
                requestNext.byteEnable = busPkg::allBytes;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateFetch;
            pc <= cpuPkg::resetVector;
            busRequest.read <= 1'b0;
            busRequest.write <= 1'b0;
        end else begin
            state <= stateNext;
            busRequest <= requestNext;
            // PC moves on once execute has sampled it
            if (state == stateExecute) begin
                pc <= nextPc;
            end
        end
    end

    // Instruction and load data are caught on the completion edge
    always_ff @(posedge clk) begin
        if (state == stateFetch && accessDone) begin
            instruction <= cpuPkg::instrT'(readData);
        end
        if (state == stateMemory && accessDone) begin
            loadData <= readData;
        end
    end

    assign active = state != stateHalt;
    assign executeStrobe = state == stateExecute;

    // Write port, ALU or link in execute, load data in writeback
    assign regWriteEnable = (executeStrobe && (aluWrites || linkWrite)) ||
                            (state == stateWriteback);
    assign regWriteIndex = (executeStrobe && linkWrite) ? linkIndex : aluDestination;

    always_comb begin
        if (state == stateWriteback) begin
            regWriteData = loadData;
        end else if (linkWrite) begin
            regWriteData = linkValue;
        end else begin
            regWriteData = aluResult;
        end
    end

endmodule

// ==== mipsCpuBus.sv ====
`timescale 1ns/1ps

module mipsCpuBus (
    input  logic               clk,
    input  logic               reset,
    input  logic               waitRequest,
    input  cpuPkg::wordT       readData,
    output busPkg::busRequestT busRequest,
    output logic               active,
    output cpuPkg::wordT       registerV0
);

    cpuPkg::instrT    instruction;
    cpuPkg::wordT     pc;
    cpuPkg::wordT     operandA;
    cpuPkg::wordT     operandB;
    cpuPkg::wordT     aluResult;
    cpuPkg::regIndexT aluDestination;
    cpuPkg::wordT     nextPc;
    cpuPkg::regIndexT linkIndex;
    cpuPkg::wordT     linkValue;
    cpuPkg::regIndexT regWriteIndex;
    cpuPkg::wordT     regWriteData;
    logic             executeStrobe;
    logic             aluWrites;
    logic             linkWrite;
    logic             regWriteEnable;

    // Sequencing, bus master and register write port
    controlFsm controlFsm_i (
        .clk            (clk),
        .reset          (reset),
        .waitRequest    (waitRequest),
        .readData       (readData),
        .busRequest     (busRequest),
        .active         (active),
        .instruction    (instruction),
        .pc             (pc),
        .executeStrobe  (executeStrobe),
        .aluResult      (aluResult),
        .aluDestination (aluDestination),
        .aluWrites      (aluWrites),
        .storeData      (operandB),
        .nextPc         (nextPc),
        .linkWrite      (linkWrite),
        .linkIndex      (linkIndex),
        .linkValue      (linkValue),
        .regWriteEnable (regWriteEnable),
        .regWriteIndex  (regWriteIndex),
        .regWriteData   (regWriteData)
    );

    // Read ports follow rs and rt of the held instruction
    registerFile registerFile_i (
        .clk         (clk),
        .reset       (reset),
        .readIndexA  (instruction.rs),
        .readIndexB  (instruction.rt),
        .writeIndex  (regWriteIndex),
        .writeEnable (regWriteEnable),
        .writeData   (regWriteData),
        .readDataA   (operandA),
        .readDataB   (operandB),
        .registerV0  (registerV0)
    );

    alu alu_i (
        .instruction    (instruction),
        .operandA       (operandA),
        .operandB       (operandB),
        .result         (aluResult),
        .destination    (aluDestination),
        .writesRegister (aluWrites)
    );

    branchUnit branchUnit_i (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .operandA      (operandA),
        .operandB      (operandB),
        .pc            (pc),
        .executeStrobe (executeStrobe),
        .nextPc        (nextPc),
        .linkWrite     (linkWrite),
        .linkIndex     (linkIndex),
        .linkValue     (linkValue)
    );

endmodule

// ==== mipsCpuBusChecker.sv ====
`timescale 1ns/1ps

module mipsCpuBusChecker (
    input  logic               clk,
    input  logic               reset,
    input  logic               active,
    input  cpuPkg::wordT       registerV0,
    input  busPkg::busRequestT busRequest,
    input  logic               waitRequest,
    input  logic [2:0]         testIndex,
    input  cpuPkg::wordT       expectedV0,
    input  cpuPkg::wordT       expectedData,
    input  cpuPkg::wordT       observedData,
    output int                 passCount,
    output int                 failCount
);

    int   passes = 0;
    int   fails = 0;
    logic activeQ;
    logic testOk;
    logic busOk;

    assign passCount = passes;
    assign failCount = fails;

    // One Fail line per wrong value
    task automatic compareWord(
        input string        name,
        input cpuPkg::wordT actual,
        input cpuPkg::wordT expected,
        inout logic         ok
    );
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        activeQ <= active;
        if (reset) begin
            busOk = 1'b1;
        end else if ((busRequest.read || busRequest.write) && !waitRequest) begin
            // Word accesses only, so all four lanes on every transfer
            compareWord("byteEnable", 32'(busRequest.byteEnable), 32'h0000_000F, busOk);
        end
        // Falling edge of active marks the halt of a program
        if (!reset && activeQ === 1'b1 && active === 1'b0) begin
            testOk = busOk;
            compareWord("registerV0", registerV0, expectedV0, testOk);
            // Data word at the test's check address
            compareWord("data word", observedData, expectedData, testOk);
            if (testOk) begin
                passes <= passes + 1;
                $display("test %0d passed at %0t ns", testIndex, $time);
            end else begin
                fails <= fails + 1;
                $display("test %0d failed at %0t ns", testIndex, $time);
            end
        end
    end

endmodule

// ==== mipsCpuBusTb.sv ====
`timescale 1ns/1ps

module mipsCpuBusTb;

    localparam int numTests = 5;
    localparam int resetCycles = 4;
    localparam int clockPeriodNs = 4;
    // Up to 12 instructions of about 8 cycles each per test
    localparam int watchdogNs = numTests * 12 * 8 * clockPeriodNs + 2000;
    // Small data region at low addresses
    localparam cpuPkg::wordT dataBase = 32'h0000_0100;

    // One program with its start data and expected results
    typedef struct packed {
        cpuPkg::wordT [11:0] code;
        cpuPkg::wordT [3:0]  data;
        logic [3:0]          checkIndex;
        cpuPkg::wordT        expectData;
        cpuPkg::wordT        expectV0;
    } testT;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               waitRequest = 1'b1;
    cpuPkg::wordT       readData = '0;
    busPkg::busRequestT busRequest;
    logic               active;
    cpuPkg::wordT       registerV0;
    logic [2:0]         testIndex = '0;
    testT               tests [numTests];
    cpuPkg::wordT       codeMem [16];
    cpuPkg::wordT       dataMem [16];
    cpuPkg::wordT       expectedV0;
    cpuPkg::wordT       expectedData;
    cpuPkg::wordT       observedData;
    logic [3:0]         wordIndex;
    logic               codeHit;
    logic               dataHit;
    logic               pending;
    int                 waitLeft;
    int                 waitsToGo;
    int                 passCount;
    int                 failCount;
    int                 seed = 41394;

    always #2 clk = ~clk;

    mipsCpuBus mipsCpuBus_i (
        .clk         (clk),
        .reset       (reset),
        .waitRequest (waitRequest),
        .readData    (readData),
        .busRequest  (busRequest),
        .active      (active),
        .registerV0  (registerV0)
    );

    mipsCpuBusChecker checker_i (
        .clk          (clk),
        .reset        (reset),
        .active       (active),
        .registerV0   (registerV0),
        .busRequest   (busRequest),
        .waitRequest  (waitRequest),
        .testIndex    (testIndex),
        .expectedV0   (expectedV0),
        .expectedData (expectedData),
        .observedData (observedData),
        .passCount    (passCount),
        .failCount    (failCount)
    );

    assign expectedV0 = tests[testIndex].expectV0;
    assign expectedData = tests[testIndex].expectData;
    assign observedData = dataMem[tests[testIndex].checkIndex];

    // Instruction encoders
    function automatic cpuPkg::wordT rType(cpuPkg::functT fn, int rd, int rs, int rt);
        return {cpuPkg::opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic cpuPkg::wordT shiftImm(cpuPkg::functT fn, int rd, int rt, int amount);
        return {cpuPkg::opSpecial, 5'd0, 5'(rt), 5'(rd), 5'(amount), fn};
    endfunction

    function automatic cpuPkg::wordT iType(cpuPkg::opcodeT op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic cpuPkg::wordT regimm(cpuPkg::regimmT cond, int rs, int offset);
        return {cpuPkg::opRegimm, 5'(rs), cond, 16'(offset)};
    endfunction

    function automatic cpuPkg::wordT jump(cpuPkg::opcodeT op, cpuPkg::wordT target);
        return {op, target[27:2]};
    endfunction

    // Zero words in a program decode as NOP
    task automatic buildPrograms();
        for (int t = 0; t < numTests; t++) begin
            tests[t] = '0;
        end
        // Arithmetic and logic
        tests[0].code[0] = iType(cpuPkg::opLui, 8, 0, 'h1234);
        tests[0].code[1] = iType(cpuPkg::opOri, 8, 8, 'h5678);
        tests[0].code[2] = iType(cpuPkg::opAddiu, 9, 0, -1);
        tests[0].code[3] = rType(cpuPkg::fnAddu, 10, 8, 9);
        tests[0].code[4] = rType(cpuPkg::fnSubu, 11, 8, 10);
        tests[0].code[5] = rType(cpuPkg::fnAnd, 12, 8, 9);
        tests[0].code[6] = rType(cpuPkg::fnXor, 13, 12, 10);
        tests[0].code[7] = rType(cpuPkg::fnSlt, 14, 9, 11);
        tests[0].code[8] = rType(cpuPkg::fnAddu, 2, 10, 13);
        tests[0].code[9] = rType(cpuPkg::fnAddu, 2, 2, 14);
        tests[0].code[10] = rType(cpuPkg::fnJr, 0, 31, 0);
        tests[0].data[0] = 'hCAFE_F00D;
        tests[0].expectData = 'hCAFE_F00D;
        tests[0].expectV0 = 'h1234_5687;
        // Shifts of a negative word by 4 and by its own low bits (16)
        tests[1].code[0] = iType(cpuPkg::opLui, 8, 0, 'hF000);
        tests[1].code[1] = iType(cpuPkg::opOri, 8, 8, 'h00F0);
        tests[1].code[2] = shiftImm(cpuPkg::fnSra, 9, 8, 4);
        tests[1].code[3] = shiftImm(cpuPkg::fnSrl, 10, 8, 4);
        tests[1].code[4] = shiftImm(cpuPkg::fnSll, 11, 8, 4);
        tests[1].code[5] = rType(cpuPkg::fnSrav, 13, 8, 8);
        tests[1].code[6] = rType(cpuPkg::fnSllv, 14, 8, 8);
        tests[1].code[7] = rType(cpuPkg::fnXor, 2, 9, 10);
        tests[1].code[8] = rType(cpuPkg::fnXor, 2, 2, 13);
        tests[1].code[9] = rType(cpuPkg::fnOr, 2, 2, 11);
        tests[1].code[10] = rType(cpuPkg::fnXor, 2, 2, 14);
        tests[1].code[11] = rType(cpuPkg::fnJr, 0, 31, 0);
        tests[1].data[0] = 'h0BAD_0001;
        tests[1].expectData = 'h0BAD_0001;
        tests[1].expectV0 = 'h0F0F_FF00;
        // Store, reload at once, then add a preset word
        tests[2].code[0] = iType(cpuPkg::opLui, 8, 0, 'hA5A5);
        tests[2].code[1] = iType(cpuPkg::opOri, 8, 8, 'h1234);
        tests[2].code[2] = iType(cpuPkg::opAddiu, 9, 0, 'h100);
        tests[2].code[3] = iType(cpuPkg::opSw, 8, 9, 8);
        tests[2].code[4] = iType(cpuPkg::opLw, 2, 9, 8);
        tests[2].code[5] = iType(cpuPkg::opLw, 10, 9, 4);
        tests[2].code[6] = rType(cpuPkg::fnAddu, 2, 2, 10);
        tests[2].code[7] = rType(cpuPkg::fnJr, 0, 31, 0);
        tests[2].data[1] = 'h0000_0777;
        tests[2].checkIndex = 4'd2;
        tests[2].expectData = 'hA5A5_1234;
        tests[2].expectV0 = 'hA5A5_19AB;
        // Branches on -5 with delay slots adding 1, 2, 4 and 8
        tests[3].code[0] = iType(cpuPkg::opAddiu, 8, 0, -5);
        tests[3].code[1] = iType(cpuPkg::opBeq, 0, 8, 2);
        tests[3].code[2] = iType(cpuPkg::opAddiu, 2, 2, 1);
        tests[3].code[3] = iType(cpuPkg::opBne, 0, 8, 2);
        tests[3].code[4] = iType(cpuPkg::opAddiu, 2, 2, 2);
        tests[3].code[5] = iType(cpuPkg::opAddiu, 2, 2, 'h100);
        tests[3].code[6] = regimm(cpuPkg::rtBltz, 8, 2);
        tests[3].code[7] = iType(cpuPkg::opAddiu, 2, 2, 4);
        tests[3].code[8] = iType(cpuPkg::opAddiu, 2, 2, 'h200);
        tests[3].code[9] = regimm(cpuPkg::rtBgez, 8, 2);
        tests[3].code[10] = iType(cpuPkg::opAddiu, 2, 2, 8);
        tests[3].code[11] = rType(cpuPkg::fnJr, 0, 31, 0);
        tests[3].data[3] = 'h1357_9BDF;
        tests[3].checkIndex = 4'd3;
        tests[3].expectData = 'h1357_9BDF;
        tests[3].expectV0 = 'h0000_000F;
        // JAL to word 4 and JALR to word 8 with links summed into $v0
        tests[4].code[0] = jump(cpuPkg::opJal, cpuPkg::resetVector + 16);
        tests[4].code[1] = iType(cpuPkg::opAddiu, 9, 0, 3);
        tests[4].code[2] = iType(cpuPkg::opAddiu, 9, 9, 'h100);
        tests[4].code[3] = iType(cpuPkg::opAddiu, 9, 9, 'h100);
        tests[4].code[4] = iType(cpuPkg::opAddiu, 10, 31, 24);
        tests[4].code[5] = rType(cpuPkg::fnJalr, 12, 10, 0);
        tests[4].code[6] = iType(cpuPkg::opAddiu, 9, 9, 4);
        tests[4].code[7] = iType(cpuPkg::opAddiu, 9, 9, 'h100);
        tests[4].code[8] = rType(cpuPkg::fnAddu, 2, 12, 9);
        tests[4].code[9] = rType(cpuPkg::fnAddu, 2, 2, 31);
        tests[4].code[10] = rType(cpuPkg::fnJr, 0, 0, 0);
        tests[4].data[0] = 'h2468_ACE0;
        tests[4].expectData = 'h2468_ACE0;
        tests[4].expectV0 = 'h7F80_002B;
    endtask

    // Code sits at the reset vector and data at dataBase
    assign wordIndex = busRequest.address[5:2];
    assign codeHit = busRequest.address[31:6] == cpuPkg::resetVector[31:6];
    assign dataHit = busRequest.address[31:6] == dataBase[31:6];

    // Avalon slave with 0 to 2 extra wait cycles and loaded during reset
    always @(posedge clk) begin
        if (reset) begin
            waitRequest <= 1'b1;
            pending <= 1'b0;
            waitLeft <= 0;
            for (int i = 0; i < 12; i++) begin
                codeMem[i] <= tests[testIndex].code[i];
            end
            for (int i = 12; i < 16; i++) begin
                codeMem[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                dataMem[i] <= tests[testIndex].data[i];
            end
            for (int i = 4; i < 16; i++) begin
                dataMem[i] <= '0;
            end
        end else if (busRequest.read || busRequest.write) begin
            if (!waitRequest) begin
                // Access completes on this edge
                if (busRequest.write && dataHit) begin
                    dataMem[wordIndex] <= busRequest.writeData;
                end
                waitRequest <= 1'b1;
                pending <= 1'b0;
            end else begin
                if (pending) begin
                    waitsToGo = waitLeft;
                end else begin
                    waitsToGo = {$random(seed)} % 3;
                end
                pending <= 1'b1;
                if (waitsToGo == 0) begin
                    waitRequest <= 1'b0;
                    readData <= dataHit ? dataMem[wordIndex] :
                                codeHit ? codeMem[wordIndex] : '0;
                end else begin
                    waitLeft <= waitsToGo - 1;
                end
            end
        end
    end

    // Test loop
    initial begin
        buildPrograms();
        for (int t = 0; t < numTests; t++) begin
            @(posedge clk);
            testIndex <= 3'(t);
            reset <= 1'b1;
            repeat (resetCycles) @(posedge clk);
            reset <= 1'b0;
            @(posedge clk);
            while (active !== 1'b0) begin
                @(posedge clk);
            end
            // Give the checker its edge
            repeat (2) @(posedge clk);
        end
        $display("%0d tests, %0d passed, %0d failed", numTests, passCount, failCount);
        if (failCount == 0 && passCount == numTests) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (passCount + failCount != numTests) begin
                $display("not every test was checked after its halt");
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdogNs);
        $display("timeout: processor never halted");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
cpuPkg.sv
busPkg.sv
registerFile.sv
alu.sv
branchUnit.sv
controlFsm.sv
mipsCpuBus.sv
mipsCpuBusChecker.sv
mipsCpuBusTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f files.f --top-module mipsCpuBusTb -o simv \
    && ./obj_dir/simv 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
